// File: rtl/fpFormatPkg.sv
// Single-precision field widths, vector types and the operand pair shared by the adder and bench
package fpFormatPkg;

    localparam int EXP_W = 8;
    localparam int FRAC_W = 23;
    // Hidden bit plus stored fraction
    localparam int SIG_W = FRAC_W + 1;
    // Guard, round and sticky below the significand
    localparam int EXT_W = SIG_W + 3;
    localparam int SHIFT_W = 5;
    // Largest alignment shift kept; anything further lands wholly in sticky
    localparam int MAX_ALIGN = 26;

    typedef logic [EXP_W+FRAC_W:0] fpWord;
    typedef logic [EXP_W-1:0] expField;
    typedef logic [FRAC_W-1:0] fracField;
    typedef logic [SIG_W-1:0] sigVec;
    typedef logic [EXT_W-1:0] extSig;
    typedef logic [SHIFT_W-1:0] shiftCount;

    localparam expField EXP_INF = 8'hFF;

    // Operands as presented on the request port
    typedef struct packed {
        fpWord opA;
        fpWord opB;
        logic subtract;
    } opPair;

endpackage

// File: rtl/fpStagePkg.sv
// Stage-to-stage register contents of the floating point adder pipeline
package fpStagePkg;

    // Unpack stage result, operands ordered by magnitude
    typedef struct packed {
        logic largeSign;
        logic effSub;
        fpFormatPkg::expField largeExp;
        fpFormatPkg::sigVec largeSig;
        fpFormatPkg::sigVec smallSig;
        fpFormatPkg::shiftCount expDiff;
        logic smallZero;
    } unpackedOps;

    // Both significands on a common exponent
    typedef struct packed {
        logic sign;
        logic effSub;
        fpFormatPkg::expField exponent;
        fpFormatPkg::extSig largeExt;
        fpFormatPkg::extSig smallExt;
    } alignedOps;

    // Raw sum before normalization
    typedef struct packed {
        logic alignedSign;
        fpFormatPkg::expField exponentOut;
        fpFormatPkg::sigVec alignedResult;
        logic carryOut;
        logic guardBit;
        logic roundBit;
        logic stickyBit;
    } sumResult;

endpackage

// File: rtl/operandUnpack.sv
// First adder stage: splits both operands, applies subtract and orders them by magnitude
`timescale 1ns/1ps

module operandUnpack (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  fpFormatPkg::opPair ops,
    output fpStagePkg::unpackedOps stageOut
);
    logic signA;
    logic signB;
    logic aLarger;
    fpFormatPkg::expField expA;
    fpFormatPkg::expField expB;
    fpFormatPkg::sigVec sigA;
    fpFormatPkg::sigVec sigB;
    fpFormatPkg::expField rawDiff;
    fpStagePkg::unpackedOps stageNext;

    always_comb
    begin
        signA = ops.opA[31];
        // Subtraction flips the second sign
        signB = ops.opB[31] ^ ops.subtract;
        expA = ops.opA[30:23];
        expB = ops.opB[30:23];
        // Denormals read as zero
        sigA = (expA == '0) ? '0 : {1'b1, ops.opA[22:0]};
        sigB = (expB == '0) ? '0 : {1'b1, ops.opB[22:0]};

        // Exponent first, fraction breaks ties
        aLarger = {expA, sigA} >= {expB, sigB};

        stageNext.effSub = signA ^ signB;
        stageNext.largeSign = aLarger ? signA : signB;
        stageNext.largeExp = aLarger ? expA : expB;
        stageNext.largeSig = aLarger ? sigA : sigB;
        stageNext.smallSig = aLarger ? sigB : sigA;
        stageNext.smallZero = aLarger ? (expB == '0) : (expA == '0);

        rawDiff = aLarger ? (expA - expB) : (expB - expA);
        if (rawDiff > fpFormatPkg::expField'(fpFormatPkg::MAX_ALIGN))
            stageNext.expDiff = fpFormatPkg::shiftCount'(fpFormatPkg::MAX_ALIGN);
        else
            stageNext.expDiff = rawDiff[fpFormatPkg::SHIFT_W-1:0];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            stageOut <= '0;
        else if (load)
            stageOut <= stageNext;
    end

endmodule

// File: rtl/mantissaAlign.sv
// Second adder stage: right-shifts the smaller significand and gathers guard, round and sticky
`timescale 1ns/1ps

module mantissaAlign (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  fpStagePkg::unpackedOps stageIn,
    output fpStagePkg::alignedOps stageOut
);
    localparam int WIDE_W = fpFormatPkg::SIG_W + fpFormatPkg::MAX_ALIGN;

    logic [WIDE_W-1:0] shiftWide;
    logic stickyOut;
    fpStagePkg::alignedOps stageNext;

    always_comb
    begin
        // Room below the significand for the full saturated shift
        shiftWide = {stageIn.smallSig, {fpFormatPkg::MAX_ALIGN{1'b0}}} >> stageIn.expDiff;

        // Everything under the round position collapses into sticky
        stickyOut = |shiftWide[WIDE_W-fpFormatPkg::EXT_W:0];

        stageNext.sign = stageIn.largeSign;
        stageNext.effSub = stageIn.effSub;
        stageNext.exponent = stageIn.largeExp;
        stageNext.largeExt = {stageIn.largeSig, 3'b000};

        if (stageIn.smallZero)
            stageNext.smallExt = '0;
        else
            stageNext.smallExt = {shiftWide[WIDE_W-1 -: fpFormatPkg::EXT_W-1], stickyOut};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            stageOut <= '0;
        else if (load)
            stageOut <= stageNext;
    end

endmodule

// File: rtl/mantissaAdder.sv
// Third adder stage: adds or subtracts the aligned significands and splits the raw sum
`timescale 1ns/1ps

module mantissaAdder (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  fpStagePkg::alignedOps stageIn,
    output fpStagePkg::sumResult stageOut
);
    logic [fpFormatPkg::EXT_W:0] sumWide;
    fpStagePkg::sumResult stageNext;

    always_comb
    begin
        // Larger magnitude is always on the left, so no negative difference
        if (stageIn.effSub)
            sumWide = {1'b0, stageIn.largeExt} - {1'b0, stageIn.smallExt};
        else
            sumWide = {1'b0, stageIn.largeExt} + {1'b0, stageIn.smallExt};

        stageNext.alignedSign = stageIn.sign;
        stageNext.exponentOut = stageIn.exponent;
        stageNext.carryOut = sumWide[fpFormatPkg::EXT_W];
        stageNext.alignedResult = sumWide[fpFormatPkg::EXT_W-1:3];
        stageNext.guardBit = sumWide[2];
        stageNext.roundBit = sumWide[1];
        stageNext.stickyBit = sumWide[0];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            stageOut <= '0;
        else if (load)
            stageOut <= stageNext;
    end

endmodule

// File: rtl/normalizeRound.sv
// Fourth adder stage: renormalizes the raw sum, rounds to nearest even and packs the result
`timescale 1ns/1ps

module normalizeRound (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  fpStagePkg::sumResult stageIn,
    output fpFormatPkg::fpWord result
);
    localparam int WORK_W = fpFormatPkg::SIG_W + 2;

    logic [WORK_W-1:0] workSig;
    logic [WORK_W-1:0] shiftedWork;
    fpFormatPkg::shiftCount leadCount;
    fpFormatPkg::sigVec normSig;
    logic guardN;
    logic roundN;
    logic stickyN;
    logic roundUp;
    logic [fpFormatPkg::SIG_W:0] roundedSig;
    fpFormatPkg::sigVec finalSig;
    logic [fpFormatPkg::EXP_W+1:0] normExp;
    logic [fpFormatPkg::EXP_W+1:0] finalExp;
    logic isZero;
    logic underflow;
    fpFormatPkg::fpWord packedWord;

    // Leading zeros of significand plus guard and round
    function automatic fpFormatPkg::shiftCount leadZeros(input logic [WORK_W-1:0] value);
        fpFormatPkg::shiftCount count;
        count = fpFormatPkg::shiftCount'(WORK_W);
        for (int i = 0; i < WORK_W; i++)
            if (value[i])
                count = fpFormatPkg::shiftCount'(WORK_W - 1 - i);
        return count;
    endfunction

    always_comb
    begin
        workSig = {stageIn.alignedResult, stageIn.guardBit, stageIn.roundBit};
        leadCount = leadZeros(workSig);
        shiftedWork = workSig << leadCount;
        isZero = !stageIn.carryOut && (workSig == '0) && !stageIn.stickyBit;

        if (stageIn.carryOut)
        begin
            // Carry out of the adder, drop one bit into guard
            normSig = {1'b1, stageIn.alignedResult[fpFormatPkg::SIG_W-1:1]};
            guardN = stageIn.alignedResult[0];
            roundN = stageIn.guardBit;
            stickyN = stageIn.roundBit | stageIn.stickyBit;
            normExp = {2'b00, stageIn.exponentOut} + 1'b1;
        end
        else
        begin
            // Guard and round come in first, then zeros
            normSig = shiftedWork[WORK_W-1:2];
            guardN = shiftedWork[1];
            roundN = shiftedWork[0];
            stickyN = stageIn.stickyBit;
            normExp = {2'b00, stageIn.exponentOut} - {5'b00000, leadCount};
        end

        underflow = normExp[fpFormatPkg::EXP_W+1] || (normExp == '0);

        // Nearest even
        roundUp = guardN & (roundN | stickyN | normSig[0]);
        roundedSig = {1'b0, normSig} + roundUp;
        if (roundedSig[fpFormatPkg::SIG_W])
        begin
            finalSig = roundedSig[fpFormatPkg::SIG_W:1];
            finalExp = normExp + 1'b1;
        end
        else
        begin
            finalSig = roundedSig[fpFormatPkg::SIG_W-1:0];
            finalExp = normExp;
        end

        if (isZero)
            packedWord = '0;
        else if (underflow)
            packedWord = {stageIn.alignedSign, {(fpFormatPkg::EXP_W+fpFormatPkg::FRAC_W){1'b0}}};
        else if (finalExp >= {2'b00, fpFormatPkg::EXP_INF})
            packedWord = {stageIn.alignedSign, fpFormatPkg::EXP_INF, fpFormatPkg::fracField'(0)};
        else
            packedWord = {stageIn.alignedSign, finalExp[fpFormatPkg::EXP_W-1:0],
                          finalSig[fpFormatPkg::FRAC_W-1:0]};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            result <= '0;
        else if (load)
            result <= packedWord;
    end

endmodule

// File: rtl/pipeCtrl.sv
// Pipeline controller: stage valid bits, load enables and both four-phase req/ack handshakes
`timescale 1ns/1ps

module pipeCtrl (
    input  logic clk,
    input  logic rst,
    input  logic inReq,
    output logic inAck,
    output logic outReq,
    input  logic outAck,
    output logic load1,
    output logic load2,
    output logic load3,
    output logic load4
);
    typedef enum logic [1:0] {
        outIdle,
        outWait,
        outRelease
    } outPhase;

    outPhase outState;
    logic valid1;
    logic valid2;
    logic valid3;
    logic valid4;
    logic drain4;

    // Sink has taken the result in stage four
    assign drain4 = (outState == outWait) && outAck;

    // Stall ripples back from the oldest stage
    assign load4 = valid3 && (!valid4 || drain4);
    assign load3 = valid2 && (!valid3 || load4);
    assign load2 = valid1 && (!valid2 || load3);
    assign load1 = inReq && !inAck && (!valid1 || load2);

    assign outReq = (outState == outWait);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            valid3 <= 1'b0;
            valid4 <= 1'b0;
        end
        else
        begin
            valid1 <= load1 || (valid1 && !load2);
            valid2 <= load2 || (valid2 && !load3);
            valid3 <= load3 || (valid3 && !load4);
            valid4 <= load4 || (valid4 && !drain4);
        end
    end

    // Input side acknowledge
    always_ff @(posedge clk)
    begin
        if (rst)
            inAck <= 1'b0;
        else if (load1)
            inAck <= 1'b1;
        else if (inAck && !inReq)
            inAck <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            outState <= outIdle;
        else
        begin
            case (outState)
                outIdle:
                    if (!outAck && (valid4 || load4))
                        outState <= outWait;
                outWait:
                    if (outAck)
                        outState <= outRelease;
                outRelease:
                    if (!outAck)
                        outState <= outIdle;
                default:
                    outState <= outIdle;
            endcase
        end
    end

endmodule

// File: rtl/fpAddTop.sv
// Pipelined single-precision adder/subtractor with four-phase request and result ports
`timescale 1ns/1ps

module fpAddTop (
    input  logic clk,
    input  logic rst,
    input  logic inReq,
    output logic inAck,
    input  fpFormatPkg::opPair ops,
    output logic outReq,
    input  logic outAck,
    output fpFormatPkg::fpWord result
);
    logic load1;
    logic load2;
    logic load3;
    logic load4;
    fpStagePkg::unpackedOps stage1;
    fpStagePkg::alignedOps stage2;
    fpStagePkg::sumResult stage3;

    pipeCtrl uCtrl (
        .clk(clk),
        .rst(rst),
        .inReq(inReq),
        .inAck(inAck),
        .outReq(outReq),
        .outAck(outAck),
        .load1(load1),
        .load2(load2),
        .load3(load3),
        .load4(load4)
    );

    operandUnpack uUnpack (
        .clk(clk),
        .rst(rst),
        .load(load1),
        .ops(ops),
        .stageOut(stage1)
    );

    mantissaAlign uAlign (
        .clk(clk),
        .rst(rst),
        .load(load2),
        .stageIn(stage1),
        .stageOut(stage2)
    );

    mantissaAdder uAdder (
        .clk(clk),
        .rst(rst),
        .load(load3),
        .stageIn(stage2),
        .stageOut(stage3)
    );

    normalizeRound uNormalize (
        .clk(clk),
        .rst(rst),
        .load(load4),
        .stageIn(stage3),
        .result(result)
    );

endmodule

// File: bench/clockGen.sv
// Bench clock and synchronous reset source; reset stays high for a set number of cycles
`timescale 1ns/1ps

module clockGen #(
    parameter int PERIOD = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES)
            @(posedge clk);
        // Release between edges
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: bench/fpAddTop_asserts.sv
// Handshake and stability properties of the adder ports, attached to fpAddTop through bind
`timescale 1ns/1ps

module fpAddTop_asserts (
    input logic clk,
    input logic rst,
    input logic inReq,
    input logic inAck,
    input fpFormatPkg::opPair ops,
    input logic outReq,
    input logic outAck,
    input fpFormatPkg::fpWord result
);
    int failCount = 0;

    // Operands held while the request waits
    opsHeld: assert property (@(posedge clk) disable iff (rst)
        inReq && $past(inReq && !inAck) |-> $stable(ops))
    else
    begin
        failCount++;
        $error("operands changed while inReq waited for inAck");
    end

    resultHeld: assert property (@(posedge clk) disable iff (rst)
        outReq && $past(outReq) |-> $stable(result))
    else
    begin
        failCount++;
        $error("result changed while outReq was high");
    end

    // New request only once the sink has released
    reqAfterRelease: assert property (@(posedge clk) disable iff (rst)
        $rose(outReq) |-> !$past(outAck))
    else
    begin
        failCount++;
        $error("outReq rose while outAck was high");
    end

endmodule

bind fpAddTop fpAddTop_asserts uAsserts (
    .clk(clk),
    .rst(rst),
    .inReq(inReq),
    .inAck(inAck),
    .ops(ops),
    .outReq(outReq),
    .outAck(outAck),
    .result(result)
);

// File: bench/fpAddTb.sv
// Random and directed bench for the pipelined adder with a reference model and scoreboard
`timescale 1ns/1ps

module fpAddTb;
    localparam int PERIOD = 100;
    localparam int RANDOM_OPS = 500;
    localparam int NEAR_OPS = 100;
    localparam int EDGE_OPS = 100;
    localparam int STALL_OPS = 200;
    localparam int TOTAL_OPS = RANDOM_OPS + NEAR_OPS + 1 + EDGE_OPS + STALL_OPS;

    logic clk;
    logic rst;
    logic inReq;
    logic inAck;
    logic outReq;
    logic outAck;
    fpFormatPkg::opPair ops;
    fpFormatPkg::fpWord result;

    fpFormatPkg::fpWord expected[$];
    int seed = 32'h9550320d;
    int stallSeed = 32'h9550320d;
    int errorCount = 0;
    int markErrors = 0;
    int issued = 0;
    int received = 0;

    clockGen #(.PERIOD(PERIOD), .RESET_CYCLES(3)) uClock (.clk(clk), .rst(rst));

    fpAddTop i_fpAddTop (
        .clk(clk),
        .rst(rst),
        .inReq(inReq),
        .inAck(inAck),
        .ops(ops),
        .outReq(outReq),
        .outAck(outAck),
        .result(result)
    );

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want)
        begin
            $display("[ERROR] %s: got %h, expected %h", name, got, want);
            errorCount++;
        end
    endtask

    // Normal operand, random sign, exponent in lo..hi
    function automatic fpFormatPkg::fpWord randomWord(input int lo, input int hi);
        fpFormatPkg::expField e;
        e = fpFormatPkg::expField'(lo + $unsigned($random(seed)) % (hi - lo + 1));
        return {1'($random(seed)), e, fpFormatPkg::fracField'($random(seed))};
    endfunction

    // Exact aligned sum in 64 bits, larger significand at [55:32], then one rounding
    function automatic fpFormatPkg::fpWord modelSum(input fpFormatPkg::opPair p);
        fpFormatPkg::fpWord a;
        fpFormatPkg::fpWord b;
        logic [63:0] magL;
        logic [63:0] magS;
        logic [63:0] sum;
        logic [63:0] rem;
        logic [63:0] half;
        logic [24:0] mant;
        int lead;
        int e;
        a = p.opA;
        b = {p.opB[31] ^ p.subtract, p.opB[30:0]};
        if (b[30:0] > a[30:0])
        begin
            a = b;
            b = p.opA;
        end
        magL = (a[30:23] == 0) ? 64'd0 : {40'd1, a[22:0]} << 32;
        magS = {40'd1, b[22:0]};
        if (b[30:23] == 0)
            magS = 64'd0;
        else if (a[30:23] - b[30:23] > 32)
            // Far below every rounding boundary so only its presence matters
            magS = 64'd1;
        else
            magS = magS << (32 - (a[30:23] - b[30:23]));
        sum = (a[31] != b[31]) ? magL - magS : magL + magS;
        if (sum == 0)
            return 32'h0000_0000;
        lead = 63;
        while (!sum[lead])
            lead--;
        e = a[30:23] + lead - 55;
        if (e <= 0)
            return {a[31], 31'd0};
        mant = 25'(sum >> (lead - 23));
        rem = sum & ((64'd1 << (lead - 23)) - 1);
        half = 64'd1 << (lead - 24);
        if (rem > half || (rem == half && mant[0]))
            mant = mant + 1;
        if (mant[24])
        begin
            mant = mant >> 1;
            e++;
        end
        if (e >= 255)
            return {a[31], 8'hFF, 23'd0};
        return {a[31], e[7:0], mant[22:0]};
    endfunction

    // One four-phase request with the expected word queued at capture
    task automatic sendOp(input fpFormatPkg::fpWord a, input fpFormatPkg::fpWord b,
                          input logic sub);
        @(negedge clk);
        ops = {a, b, sub};
        inReq = 1'b1;
        while (!inAck)
            @(negedge clk);
        expected.push_back(modelSum(ops));
        issued++;
        inReq = 1'b0;
        while (inAck)
            @(negedge clk);
    endtask

    task automatic endTest(input string name);
        while (received != issued)
            @(negedge clk);
        $display("Test %s finished with %0d errors", name, errorCount - markErrors);
        markErrors = errorCount;
    endtask

    // Result sink with random stalls around each acknowledge
    initial
    begin
        outAck = 1'b0;
        forever
        begin
            @(negedge clk);
            if (outReq)
            begin
                repeat ($unsigned($random(stallSeed)) % 6)
                    @(negedge clk);
                if (expected.size() == 0)
                begin
                    $display("A result was offered with no request outstanding");
                    errorCount++;
                end
                else
                    checkValue("result", result, expected.pop_front());
                received++;
                outAck = 1'b1;
                while (outReq)
                    @(negedge clk);
                // Acknowledge may linger after the request drops
                repeat ($unsigned($random(stallSeed)) % 3)
                    @(negedge clk);
                outAck = 1'b0;
            end
        end
    end

    initial
    begin
        #(TOTAL_OPS * 40 * PERIOD);
        $display("Timeout: the adder stopped answering before all operations completed");
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        fpFormatPkg::fpWord a;
        fpFormatPkg::fpWord b;
        inReq = 1'b0;
        ops = '0;
        @(negedge clk);
        while (rst)
            @(negedge clk);

        checkValue("inAck", inAck, 0);
        repeat (10)
        begin
            @(negedge clk);
            checkValue("outReq", outReq, 0);
        end
        endTest("reset idle");

        repeat (RANDOM_OPS)
            sendOp(randomWord(1, 254), randomWord(1, 254), 1'b0);
        endTest("random add");

        // Same sign subtract with exponents equal or one apart
        repeat (NEAR_OPS)
        begin
            a = randomWord(2, 254);
            b = a;
            b[30:23] = a[30:23] - 8'($unsigned($random(seed)) % 2);
            b[22:0] = a[22:0] ^ (23'($random(seed)) >> ($unsigned($random(seed)) % 23));
            sendOp(a, b, 1'b1);
        end
        sendOp(a, a, 1'b1);
        endTest("near cancel");

        repeat (EDGE_OPS / 2)
        begin
            a = randomWord(250, 254);
            b = randomWord(250, 254);
            b[31] = a[31];
            sendOp(a, b, 1'b0);
            a = randomWord(2, 4);
            b = a;
            b[30:23] = a[30:23] - 8'($unsigned($random(seed)) % 2);
            b[22:0] = a[22:0] ^ (23'($random(seed)) >> ($unsigned($random(seed)) % 23));
            sendOp(a, b, 1'b1);
        end
        endTest("overflow and flush");

        repeat (STALL_OPS)
            sendOp(randomWord(1, 254), randomWord(1, 254), 1'($random(seed)));
        endTest("stalled mix");
        // Idle window in which no further result may appear
        repeat (20)
            @(negedge clk);
        checkValue("expected queue size", expected.size(), 0);
        checkValue("result count", received, issued);

        errorCount += i_fpAddTop.uAsserts.failCount;
        $display("Summary: %0d requests, %0d results, %0d errors", issued, received, errorCount);
        if (errorCount == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: sim.f
rtl/fpFormatPkg.sv
rtl/fpStagePkg.sv
rtl/operandUnpack.sv
rtl/mantissaAlign.sv
rtl/mantissaAdder.sv
rtl/normalizeRound.sv
rtl/pipeCtrl.sv
rtl/fpAddTop.sv
bench/clockGen.sv
bench/fpAddTop_asserts.sv
bench/fpAddTb.sv

// File: Makefile
SIM = obj_dir/VfpAddTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module fpAddTb -f sim.f -Mdir obj_dir

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
